//--- rtl/fpx_pkg.sv
package fpx_pkg;

  // OP-FP major opcode
  localparam logic [6:0] FPX_OPC_OP_FP = 7'b1010011;

  // funct7 codes, single precision (fmt bits 26:25 are 00)
  localparam logic [6:0] FPX_F7_FSGNJ        = 7'b0010000;
  localparam logic [6:0] FPX_F7_FMINMAX      = 7'b0010100;
  localparam logic [6:0] FPX_F7_FCMP         = 7'b1010000;
  localparam logic [6:0] FPX_F7_FCLASS_FMVXW = 7'b1110000;
  localparam logic [6:0] FPX_F7_FMVWX        = 7'b1111000;
  localparam logic [6:0] FPX_F7_FCVTSW       = 7'b1101000;

  // funct3 variants for the sign injection group
  localparam logic [2:0] FPX_F3_FSGNJ  = 3'b000;
  localparam logic [2:0] FPX_F3_FSGNJN = 3'b001;
  localparam logic [2:0] FPX_F3_FSGNJX = 3'b010;

  // funct3 variants for min/max
  localparam logic [2:0] FPX_F3_FMIN = 3'b000;
  localparam logic [2:0] FPX_F3_FMAX = 3'b001;

  // funct3 variants for compares
  localparam logic [2:0] FPX_F3_FLE = 3'b000;
  localparam logic [2:0] FPX_F3_FLT = 3'b001;
  localparam logic [2:0] FPX_F3_FEQ = 3'b010;

  // Move and classify share funct7, split on funct3
  localparam logic [2:0] FPX_F3_FMV    = 3'b000;
  localparam logic [2:0] FPX_F3_FCLASS = 3'b001;

  // Rounding modes as encoded in rm and frm
  localparam logic [2:0] FPX_RM_RNE = 3'b000;
  localparam logic [2:0] FPX_RM_RTZ = 3'b001;
  localparam logic [2:0] FPX_RM_RDN = 3'b010;
  localparam logic [2:0] FPX_RM_RUP = 3'b011;
  localparam logic [2:0] FPX_RM_RMM = 3'b100;
  localparam logic [2:0] FPX_RM_DYN = 3'b111;

  // Canonical quiet NaN
  localparam logic [31:0] FPX_CANON_NAN = 32'h7FC0_0000;

  // R-type view of the instruction word
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } fpx_instr_r_t;

  // FP view, fmt and rm pulled out of funct7 and funct3
  typedef struct packed {
    logic [4:0] funct5;
    logic [1:0] fmt;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] rm;
    logic [4:0] rd;
    logic [6:0] opcode;
  } fpx_instr_fp_t;

  typedef union packed {
    fpx_instr_r_t  r;
    fpx_instr_fp_t fp;
  } fpx_instr_u;

  // Operation class after decode
  typedef enum logic [2:0] {
    SGNJ,
    MINMAX,
    CMP,
    CLASS,
    MV_X_W,
    MV_W_X,
    CVT_S_W
  } fpx_op_e;

  // Decoded record, 10 bits
  typedef struct packed {
    fpx_op_e    op;
    logic [2:0] minor;
    logic       cvt_unsigned;
    logic [2:0] rm;
  } fpx_dec_t;

  typedef struct packed {
    logic [31:0] fp_rs1;
    logic [31:0] fp_rs2;
    logic [31:0] int_rs1;
  } fpx_operands_t;

  // Flags ordered {NV, DZ, OF, UF, NX}
  typedef struct packed {
    logic [31:0] result;
    logic [4:0]  fflags;
  } fpx_resp_t;

endpackage

//--- rtl/fpx_decode.sv
`timescale 1ns/1ps

module fpx_decode (
  input  fpx_pkg::fpx_instr_u instr_i,
  input  logic [2:0]          frm_csr_i,
  output fpx_pkg::fpx_dec_t   dec_o,
  output logic                legal_o
);
  import fpx_pkg::*;

  logic       opc_ok;
  logic       fmt_ok;
  logic [2:0] rm_res;
  logic       match;

  // Major opcode and single precision format
  assign opc_ok = (instr_i.r.opcode == FPX_OPC_OP_FP);
  assign fmt_ok = (instr_i.fp.fmt == 2'b00);

  // Dynamic rounding taken from the CSR
  assign rm_res = (instr_i.fp.rm == FPX_RM_DYN) ? frm_csr_i : instr_i.fp.rm;

  always_comb begin
    dec_o              = '0;
    dec_o.minor        = instr_i.r.funct3;
    dec_o.cvt_unsigned = instr_i.r.rs2[0];
    dec_o.rm           = rm_res;
    match              = 1'b0;

    case (instr_i.r.funct7)
      FPX_F7_FSGNJ: begin
        dec_o.op = SGNJ;
        match    = instr_i.r.funct3 inside {FPX_F3_FSGNJ, FPX_F3_FSGNJN, FPX_F3_FSGNJX};
      end
      FPX_F7_FMINMAX: begin
        dec_o.op = MINMAX;
        match    = instr_i.r.funct3 inside {FPX_F3_FMIN, FPX_F3_FMAX};
      end
      FPX_F7_FCMP: begin
        dec_o.op = CMP;
        match    = instr_i.r.funct3 inside {FPX_F3_FLE, FPX_F3_FLT, FPX_F3_FEQ};
      end
      FPX_F7_FCLASS_FMVXW: begin
        // rs2 must be zero for both
        if (instr_i.r.funct3 == FPX_F3_FCLASS) begin
          dec_o.op = CLASS;
        end else begin
          dec_o.op = MV_X_W;
        end
        match = (instr_i.r.rs2 == 5'd0) &&
                (instr_i.r.funct3 inside {FPX_F3_FMV, FPX_F3_FCLASS});
      end
      FPX_F7_FMVWX: begin
        dec_o.op = MV_W_X;
        match    = (instr_i.r.rs2 == 5'd0) && (instr_i.r.funct3 == FPX_F3_FMV);
      end
      FPX_F7_FCVTSW: begin
        // rs2 is 0 (W) or 1 (WU)
        dec_o.op = CVT_S_W;
        // Reserved modes 5 and 6 are rejected, static or dynamic
        match    = (instr_i.r.rs2[4:1] == 4'd0) && (rm_res <= FPX_RM_RMM);
      end
      default: begin
        match = 1'b0;
      end
    endcase
  end

  assign legal_o = opc_ok && fmt_ok && match;

endmodule

//--- rtl/fpx_noncomp.sv
`timescale 1ns/1ps

module fpx_noncomp (
  input  fpx_pkg::fpx_dec_t      dec_i,
  input  fpx_pkg::fpx_operands_t operands_i,
  output fpx_pkg::fpx_resp_t     resp_o
);
  import fpx_pkg::*;

  // One-hot class mask per the RISC-V FCLASS encoding
  function automatic logic [9:0] fp_class(input logic [31:0] x);
    logic       sgn;
    logic [7:0] exp;
    logic [22:0] man;
    logic [9:0] cls;
    sgn = x[31];
    exp = x[30:23];
    man = x[22:0];
    cls = '0;
    if (exp == 8'hFF) begin
      if (man == '0) begin
        cls[sgn ? 0 : 7] = 1'b1;
      end else if (man[22]) begin
        // Quiet NaN
        cls[9] = 1'b1;
      end else begin
        cls[8] = 1'b1;
      end
    end else if (exp == 8'h00) begin
      if (man == '0) begin
        cls[sgn ? 3 : 4] = 1'b1;
      end else begin
        cls[sgn ? 2 : 5] = 1'b1;
      end
    end else begin
      cls[sgn ? 1 : 6] = 1'b1;
    end
    return cls;
  endfunction

  logic [31:0] a;
  logic [31:0] b;
  logic [9:0]  a_cls;
  logic [9:0]  b_cls;
  logic        a_nan;
  logic        b_nan;
  logic        any_snan;
  logic        both_zero;
  logic        lt_ord;
  logic        f_eq;
  logic        f_lt;
  logic [31:0] min_res;
  logic [31:0] max_res;

  assign a     = operands_i.fp_rs1;
  assign b     = operands_i.fp_rs2;
  assign a_cls = fp_class(a);
  assign b_cls = fp_class(b);

  assign a_nan     = a_cls[8] | a_cls[9];
  assign b_nan     = b_cls[8] | b_cls[9];
  assign any_snan  = a_cls[8] | b_cls[8];
  assign both_zero = (a_cls[3] | a_cls[4]) & (b_cls[3] | b_cls[4]);

  // Total order on bit patterns, so -0 sorts below +0
  assign lt_ord = (a[31] != b[31]) ? a[31] :
                  (a[31] ? (a[30:0] > b[30:0]) : (a[30:0] < b[30:0]));

  // Compares treat the two zeros as equal
  assign f_eq = both_zero | (a == b);
  assign f_lt = ~both_zero & lt_ord;

  // A lone NaN yields the other operand
  always_comb begin
    if (a_nan && b_nan) begin
      min_res = FPX_CANON_NAN;
      max_res = FPX_CANON_NAN;
    end else if (a_nan) begin
      min_res = b;
      max_res = b;
    end else if (b_nan) begin
      min_res = a;
      max_res = a;
    end else begin
      min_res = lt_ord ? a : b;
      max_res = lt_ord ? b : a;
    end
  end

  always_comb begin
    resp_o = '0;
    case (dec_i.op)
      SGNJ: begin
        case (dec_i.minor)
          FPX_F3_FSGNJ:  resp_o.result = {b[31], a[30:0]};
          FPX_F3_FSGNJN: resp_o.result = {~b[31], a[30:0]};
          FPX_F3_FSGNJX: resp_o.result = {a[31] ^ b[31], a[30:0]};
          default:       resp_o.result = a;
        endcase
      end
      MINMAX: begin
        resp_o.result    = (dec_i.minor == FPX_F3_FMIN) ? min_res : max_res;
        // NV only for signaling inputs
        resp_o.fflags[4] = any_snan;
      end
      CMP: begin
        case (dec_i.minor)
          FPX_F3_FEQ: begin
            resp_o.result[0] = ~(a_nan | b_nan) & f_eq;
            resp_o.fflags[4] = any_snan;
          end
          FPX_F3_FLT: begin
            resp_o.result[0] = ~(a_nan | b_nan) & f_lt;
            resp_o.fflags[4] = a_nan | b_nan;
          end
          default: begin
            // FLE
            resp_o.result[0] = ~(a_nan | b_nan) & (f_lt | f_eq);
            resp_o.fflags[4] = a_nan | b_nan;
          end
        endcase
      end
      CLASS:   resp_o.result = {22'd0, a_cls};
      MV_X_W:  resp_o.result = a;
      MV_W_X:  resp_o.result = operands_i.int_rs1;
      // Conversions come from the converter
      default: resp_o = '0;
    endcase
  end

endmodule

//--- rtl/fpx_i2f.sv
`timescale 1ns/1ps

module fpx_i2f #(
  parameter int CVT_PIPE = 1
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               start_i,
  input  logic [31:0]        int_i,
  input  logic               unsigned_i,
  input  logic [2:0]         rm_i,
  output logic               done_o,
  output fpx_pkg::fpx_resp_t resp_o
);
  import fpx_pkg::*;

  // Normalize stage inputs
  logic        in_sign;
  logic [31:0] in_mag;
  logic [4:0]  in_lz;
  logic [31:0] in_norm;
  logic        in_zero;

  // Normalize stage outputs, registered or not
  logic        n_valid;
  logic        n_sign;
  logic        n_zero;
  logic [4:0]  n_lz;
  logic [31:0] n_norm;
  logic [2:0]  n_rm;

  // Round stage
  logic [23:0] r_sig;
  logic        r_guard;
  logic        r_sticky;
  logic        r_inexact;
  logic        r_up;
  logic [24:0] r_sum;
  logic [7:0]  r_exp;
  logic [31:0] r_result;

  // Sign only for the signed form
  assign in_sign = ~unsigned_i & int_i[31];
  assign in_mag  = in_sign ? (~int_i + 32'd1) : int_i;
  assign in_zero = (in_mag == 32'd0);

  // Leading zero count, zero input handled by in_zero
  always_comb begin
    logic found;
    found = 1'b0;
    in_lz = 5'd0;
    for (int i = 31; i >= 0; i--) begin
      if (!found && in_mag[i]) begin
        in_lz = 5'(31 - i);
        found = 1'b1;
      end
    end
  end

  // Left align so the hidden bit lands in bit 31
  assign in_norm = in_mag << in_lz;

  generate
    if (CVT_PIPE != 0) begin : g_norm_reg
      always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
          n_valid <= 1'b0;
        end else begin
          n_valid <= start_i;
        end
      end

      always_ff @(posedge clk) begin
        n_sign <= in_sign;
        n_zero <= in_zero;
        n_lz   <= in_lz;
        n_norm <= in_norm;
        n_rm   <= rm_i;
      end
    end else begin : g_norm_comb
      assign n_valid = start_i;
      assign n_sign  = in_sign;
      assign n_zero  = in_zero;
      assign n_lz    = in_lz;
      assign n_norm  = in_norm;
      assign n_rm    = rm_i;
    end
  endgenerate

  // 24-bit significand, guard is the first dropped bit
  assign r_sig     = n_norm[31:8];
  assign r_guard   = n_norm[7];
  assign r_sticky  = |n_norm[6:0];
  assign r_inexact = r_guard | r_sticky;

  always_comb begin
    case (n_rm)
      // Ties go to even
      FPX_RM_RNE: r_up = r_guard & (r_sticky | r_sig[0]);
      FPX_RM_RTZ: r_up = 1'b0;
      FPX_RM_RDN: r_up = r_inexact & n_sign;
      FPX_RM_RUP: r_up = r_inexact & ~n_sign;
      FPX_RM_RMM: r_up = r_guard;
      default:    r_up = 1'b0;
    endcase
  end

  // Carry out leaves the fraction at zero and bumps the exponent
  assign r_sum = {1'b0, r_sig} + {24'd0, r_up};
  assign r_exp = 8'd158 - {3'd0, n_lz} + {7'd0, r_sum[24]};

  assign r_result = n_zero ? 32'd0 : {n_sign, r_exp, r_sum[22:0]};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      done_o <= 1'b0;
    end else begin
      done_o <= n_valid;
    end
  end

  // Only NX can be raised by a conversion
  always_ff @(posedge clk) begin
    if (n_valid) begin
      resp_o.result <= r_result;
      resp_o.fflags <= {4'd0, r_inexact & ~n_zero};
    end
  end

  // Decode screens out reserved modes before issue
  a_rm_legal: assert property (@(posedge clk) disable iff (!rst_n)
    start_i |-> (rm_i <= FPX_RM_RMM));

endmodule

//--- rtl/fpx_ex.sv
`timescale 1ns/1ps

module fpx_ex #(
  parameter int CVT_PIPE = 1
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   op_valid_i,
  input  fpx_pkg::fpx_instr_u    instr_i,
  input  logic [2:0]             frm_csr_i,
  input  fpx_pkg::fpx_operands_t operands_i,
  output logic                   result_valid_o,
  output fpx_pkg::fpx_resp_t     resp_o,
  output logic                   illegal_o,
  output logic                   busy_o
);
  import fpx_pkg::*;

  fpx_dec_t  dec;
  logic      legal;
  logic      issue;
  logic      cvt_start;
  logic      cvt_done;
  fpx_resp_t nc_resp;
  fpx_resp_t cvt_resp;
  logic      busy_q;

  fpx_decode i_decode (
    .instr_i   (instr_i),
    .frm_csr_i (frm_csr_i),
    .dec_o     (dec),
    .legal_o   (legal)
  );

  // Accepted op and whether it goes to the converter
  assign issue     = op_valid_i & legal;
  assign cvt_start = issue & (dec.op == CVT_S_W);

  // Single cycle path
  fpx_noncomp i_noncomp (
    .dec_i      (dec),
    .operands_i (operands_i),
    .resp_o     (nc_resp)
  );

  // Int to float, result 1 + CVT_PIPE cycles later
  fpx_i2f #(
    .CVT_PIPE (CVT_PIPE)
  ) i_i2f (
    .clk        (clk),
    .rst_n      (rst_n),
    .start_i    (cvt_start),
    .int_i      (operands_i.int_rs1),
    .unsigned_i (dec.cvt_unsigned),
    .rm_i       (dec.rm),
    .done_o     (cvt_done),
    .resp_o     (cvt_resp)
  );

  // Busy from the cycle after issue through the done cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
    end else if (cvt_start) begin
      busy_q <= 1'b1;
    end else if (cvt_done) begin
      busy_q <= 1'b0;
    end
  end

  assign busy_o = busy_q;

  // Issuer holds off while busy, so the two sources never overlap
  assign result_valid_o = cvt_done | (issue & ~cvt_start);
  assign resp_o         = cvt_done ? cvt_resp : nc_resp;

  // Reject in the issue cycle with no result
  assign illegal_o = op_valid_i & ~legal;

  // Issue protocol
  a_no_issue_busy: assert property (@(posedge clk) disable iff (!rst_n)
    op_valid_i |-> !busy_o);

  // A converter result always belongs to a tracked conversion
  a_done_in_busy: assert property (@(posedge clk) disable iff (!rst_n)
    cvt_done |-> busy_o);

endmodule

//--- bench/tb_fpx_ex.sv
`timescale 1ns/1ps

module tb_fpx_ex;
  import fpx_pkg::*;

  // What the current issue is expected to do
  localparam logic [1:0] K_NC   = 2'd0;
  localparam logic [1:0] K_CVT  = 2'd1;
  localparam logic [1:0] K_ILL  = 2'd2;
  localparam logic [1:0] K_IDLE = 2'd3;

  logic          clk;
  logic          rst_n;
  logic          op_valid_i;
  fpx_instr_u    instr_i;
  logic [2:0]    frm_csr_i;
  fpx_operands_t operands_i;
  logic          result_valid_o;
  fpx_resp_t     resp_o;
  logic          illegal_o;
  logic          busy_o;

  // Expected response travels with the stimulus
  logic [1:0]    exp_kind;
  fpx_resp_t     exp_resp;
  logic          cvt_d1;
  logic          cvt_d2;
  fpx_resp_t     exp_d1;
  fpx_resp_t     exp_d2;
  logic          nc_issue;
  logic          ill_issue;

  int seed = 92;
  int errors = 0;
  int err_mark = 0;
  int tests_ok = 0;
  int tests_bad = 0;

  // One value per FCLASS bit, bit 0 first
  logic [31:0] class_vals [10] = '{32'hFF800000, 32'hBF800000, 32'h80000001, 32'h80000000,
                                   32'h00000000, 32'h00000001, 32'h3F800000, 32'h7F800000,
                                   32'h7F800001, 32'h7FC00000};

  // Exact, tie and sticky cases for the converter
  logic [31:0] cvt_vals [12] = '{32'h00000000, 32'h00000001, 32'hFFFFFFFF, 32'h00000007,
                                 32'h00000064, 32'h7FFFFFFF, 32'h80000000, 32'h80000001,
                                 32'h01000001, 32'h01000003, 32'h00FFFFFF, 32'h01234567};

  fpx_ex #(
    .CVT_PIPE (1)
  ) i_dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .op_valid_i     (op_valid_i),
    .instr_i        (instr_i),
    .frm_csr_i      (frm_csr_i),
    .operands_i     (operands_i),
    .result_valid_o (result_valid_o),
    .resp_o         (resp_o),
    .illegal_o      (illegal_o),
    .busy_o         (busy_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic is_nan(input logic [31:0] x);
    return (x[30:23] == 8'hFF) && (x[22:0] != 23'd0);
  endfunction

  function automatic logic is_snan(input logic [31:0] x);
    return is_nan(x) && !x[22];
  endfunction

  // Maps floats onto unsigned integers in IEEE order, -0 just below +0
  function automatic logic [31:0] order_key(input logic [31:0] x);
    return x[31] ? ~x : {1'b1, x[30:0]};
  endfunction

  function automatic logic [9:0] ref_class(input logic [31:0] x);
    int idx;
    if (is_nan(x)) idx = x[22] ? 9 : 8;
    else if (x[30:23] == 8'hFF) idx = x[31] ? 0 : 7;
    else if (x[30:0] == 31'd0) idx = x[31] ? 3 : 4;
    else if (x[30:23] == 8'h00) idx = x[31] ? 2 : 5;
    else idx = x[31] ? 1 : 6;
    return 10'd1 << idx;
  endfunction

  function automatic fpx_resp_t ref_nc(input logic [6:0] f7, input logic [2:0] f3,
                                       input logic [31:0] a, input logic [31:0] b,
                                       input logic [31:0] i);
    fpx_resp_t r;
    logic      unord;
    logic      eq;
    logic      lt;
    r = '0;
    unord = is_nan(a) || is_nan(b);
    eq = !unord && ((a == b) || (((a | b) & 32'h7FFFFFFF) == 32'd0));
    lt = !unord && !eq && (order_key(a) < order_key(b));
    case (f7)
      FPX_F7_FSGNJ: begin
        if (f3 == FPX_F3_FSGNJ) r.result = {b[31], a[30:0]};
        else if (f3 == FPX_F3_FSGNJN) r.result = {!b[31], a[30:0]};
        else r.result = {a[31] ^ b[31], a[30:0]};
      end
      FPX_F7_FMINMAX: begin
        r.fflags[4] = is_snan(a) || is_snan(b);
        if (is_nan(a) && is_nan(b)) r.result = FPX_CANON_NAN;
        else if (is_nan(a)) r.result = b;
        else if (is_nan(b)) r.result = a;
        else if (f3 == FPX_F3_FMAX) r.result = (order_key(a) < order_key(b)) ? b : a;
        else r.result = (order_key(a) < order_key(b)) ? a : b;
      end
      FPX_F7_FCMP: begin
        // FEQ is quiet, FLT and FLE signal on any NaN
        r.fflags[4] = (f3 == FPX_F3_FEQ) ? (is_snan(a) || is_snan(b)) : unord;
        if (f3 == FPX_F3_FEQ) r.result = {31'd0, eq};
        else if (f3 == FPX_F3_FLT) r.result = {31'd0, lt};
        else r.result = {31'd0, lt || eq};
      end
      FPX_F7_FCLASS_FMVXW: r.result = (f3 == FPX_F3_FCLASS) ? {22'd0, ref_class(a)} : a;
      default: r.result = i;
    endcase
    return r;
  endfunction

  // Integer to single, rounding decided from the dropped remainder
  function automatic fpx_resp_t ref_i2f(input logic [31:0] v, input logic uns,
                                        input logic [2:0] rm);
    fpx_resp_t   r;
    logic        sgn;
    logic [31:0] mag;
    logic [31:0] q;
    logic [31:0] rem;
    logic [31:0] half;
    logic        up;
    logic [7:0]  e;
    int          p;
    int          sh;
    r = '0;
    sgn = !uns && v[31];
    mag = sgn ? (~v + 32'd1) : v;
    if (mag == 32'd0) return r;
    p = 0;
    for (int k = 0; k < 32; k++) if (mag[k]) p = k;
    e = 8'(127 + p);
    rem = 32'd0;
    half = 32'd0;
    if (p <= 23) begin
      q = mag << (23 - p);
    end else begin
      sh = p - 23;
      q = mag >> sh;
      rem = mag & ((32'd1 << sh) - 32'd1);
      half = 32'd1 << (sh - 1);
    end
    case (rm)
      FPX_RM_RNE: up = (rem > half) || ((rem == half) && (rem != 32'd0) && q[0]);
      FPX_RM_RDN: up = (rem != 32'd0) && sgn;
      FPX_RM_RUP: up = (rem != 32'd0) && !sgn;
      FPX_RM_RMM: up = (rem != 32'd0) && (rem >= half);
      default:    up = 1'b0;
    endcase
    q = q + {31'd0, up};
    // Carry past the hidden bit renormalizes
    if (q[24]) begin
      q = q >> 1;
      e = e + 8'd1;
    end
    r.result = {sgn, e, q[22:0]};
    r.fflags = {4'd0, rem != 32'd0};
    return r;
  endfunction

  function automatic logic [31:0] mk_instr(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [2:0] f3);
    return {f7, rs2, 5'd1, f3, 5'd2, FPX_OPC_OP_FP};
  endfunction

  task automatic log_mismatch(input string sig, input logic [36:0] exp_v,
                              input logic [36:0] got_v);
    errors++;
    $display("MISMATCH %s expected %h got %h at %0t", sig, exp_v, got_v, $time);
  endtask

  task automatic log_failure(input string msg);
    errors++;
    $display("ERROR %s at %0t", msg, $time);
  endtask

  // Conversion shadow pipeline, two stages to the expected done
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cvt_d1 <= 1'b0;
      cvt_d2 <= 1'b0;
    end else begin
      cvt_d1 <= op_valid_i && (exp_kind == K_CVT);
      cvt_d2 <= cvt_d1;
      exp_d1 <= exp_resp;
      exp_d2 <= exp_d1;
    end
  end

  assign nc_issue  = op_valid_i && (exp_kind == K_NC);
  assign ill_issue = op_valid_i && (exp_kind == K_ILL);

  // Same cycle response of the non-computational path
  a_nc_valid: assert property (@(posedge clk) disable iff (!rst_n) nc_issue |-> result_valid_o)
    else log_mismatch("result_valid_o", 37'd1, 37'($sampled(result_valid_o)));
  a_nc_result: assert property (@(posedge clk) disable iff (!rst_n)
    nc_issue |-> (resp_o.result == exp_resp.result))
    else log_mismatch("resp_o.result", 37'($sampled(exp_resp.result)),
                      37'($sampled(resp_o.result)));
  a_nc_flags: assert property (@(posedge clk) disable iff (!rst_n)
    nc_issue |-> (resp_o.fflags == exp_resp.fflags))
    else log_mismatch("resp_o.fflags", 37'($sampled(exp_resp.fflags)),
                      37'($sampled(resp_o.fflags)));

  // Conversion result exactly two cycles after issue
  a_cvt_valid: assert property (@(posedge clk) disable iff (!rst_n) cvt_d2 |-> result_valid_o)
    else log_mismatch("result_valid_o", 37'd1, 37'($sampled(result_valid_o)));
  a_cvt_result: assert property (@(posedge clk) disable iff (!rst_n)
    cvt_d2 |-> (resp_o == exp_d2))
    else log_mismatch("resp_o", $sampled(exp_d2), $sampled(resp_o));
  a_no_stray: assert property (@(posedge clk) disable iff (!rst_n)
    result_valid_o |-> (cvt_d2 || nc_issue))
    else log_failure("result_valid_o pulsed with no matching issue");

  // Illegal strobe only for rejected encodings
  a_ill_strobe: assert property (@(posedge clk) disable iff (!rst_n) ill_issue |-> illegal_o)
    else log_mismatch("illegal_o", 37'd1, 37'($sampled(illegal_o)));
  a_ill_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    ill_issue |-> !result_valid_o)
    else log_mismatch("result_valid_o", 37'd0, 37'($sampled(result_valid_o)));
  a_legal_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    !ill_issue |-> !illegal_o)
    else log_mismatch("illegal_o", 37'd0, 37'($sampled(illegal_o)));

  // Busy spans the two cycles after a conversion issue
  a_busy: assert property (@(posedge clk) disable iff (!rst_n) busy_o == (cvt_d1 || cvt_d2))
    else log_mismatch("busy_o", 37'($sampled(cvt_d1 || cvt_d2)), 37'($sampled(busy_o)));

  // Called on a rising edge, returns on a rising edge
  task automatic issue(input logic [1:0] kind, input logic [31:0] instr,
                       input fpx_operands_t ops, input logic [2:0] frm,
                       input fpx_resp_t exp_r);
    int n;
    op_valid_i <= 1'b1;
    instr_i    <= instr;
    operands_i <= ops;
    frm_csr_i  <= frm;
    exp_kind   <= kind;
    exp_resp   <= exp_r;
    @(posedge clk);
    op_valid_i <= 1'b0;
    exp_kind   <= K_IDLE;
    if (kind == K_CVT) begin
      n = 0;
      do begin
        @(negedge clk);
        n++;
      end while (!result_valid_o && (n < 8));
      if (!result_valid_o) log_failure("timeout waiting for result_valid_o on a conversion");
      @(posedge clk);
    end
  endtask

  task automatic nc_op(input logic [6:0] f7, input logic [2:0] f3, input logic [31:0] a,
                       input logic [31:0] b, input logic [31:0] i);
    fpx_operands_t ops;
    ops.fp_rs1  = a;
    ops.fp_rs2  = b;
    ops.int_rs1 = i;
    issue(K_NC, mk_instr(f7, 5'd0, f3), ops, 3'd0, ref_nc(f7, f3, a, b, i));
  endtask

  // rm_field 7 takes the mode from frm
  task automatic cvt_op(input logic uns, input logic [2:0] rm_field, input logic [2:0] frm,
                        input logic [31:0] v);
    fpx_operands_t ops;
    logic [2:0]    rm;
    ops = '0;
    ops.int_rs1 = v;
    rm = (rm_field == FPX_RM_DYN) ? frm : rm_field;
    issue(K_CVT, mk_instr(FPX_F7_FCVTSW, {4'd0, uns}, rm_field), ops, frm,
          ref_i2f(v, uns, rm));
  endtask

  task automatic ill_op(input logic [31:0] instr, input logic [2:0] frm);
    issue(K_ILL, instr, '0, frm, '0);
  endtask

  task automatic minmax_cmp(input logic [31:0] a, input logic [31:0] b);
    nc_op(FPX_F7_FMINMAX, FPX_F3_FMIN, a, b, 32'd0);
    nc_op(FPX_F7_FMINMAX, FPX_F3_FMAX, a, b, 32'd0);
    nc_op(FPX_F7_FCMP, FPX_F3_FEQ, a, b, 32'd0);
    nc_op(FPX_F7_FCMP, FPX_F3_FLT, a, b, 32'd0);
    nc_op(FPX_F7_FCMP, FPX_F3_FLE, a, b, 32'd0);
  endtask

  // Lets the last checks settle, then tallies the test
  task automatic end_test(input string name);
    @(posedge clk);
    #1;
    if (errors == err_mark) begin
      tests_ok++;
      $display("test %s: ok", name);
    end else begin
      tests_bad++;
      $display("test %s: %0d errors", name, errors - err_mark);
    end
    err_mark = errors;
    @(posedge clk);
  endtask

  initial begin
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] i;
    rst_n      = 1'b0;
    op_valid_i = 1'b0;
    instr_i    = '0;
    frm_csr_i  = 3'd0;
    operands_i = '0;
    exp_kind   = K_IDLE;
    exp_resp   = '0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    for (int k = 0; k < 12; k++) begin
      a = $random(seed);
      b = $random(seed);
      i = $random(seed);
      nc_op(FPX_F7_FSGNJ, FPX_F3_FSGNJ, a, b, i);
      nc_op(FPX_F7_FSGNJ, FPX_F3_FSGNJN, a, b, i);
      nc_op(FPX_F7_FSGNJ, FPX_F3_FSGNJX, a, b, i);
      nc_op(FPX_F7_FCLASS_FMVXW, FPX_F3_FMV, a, b, i);
      nc_op(FPX_F7_FMVWX, FPX_F3_FMV, a, b, i);
    end
    end_test("sign_inject_move");

    // Zeros, quiet, signaling and double NaN pairs
    minmax_cmp(32'h00000000, 32'h80000000);
    minmax_cmp(32'h80000000, 32'h00000000);
    minmax_cmp(32'h7FC00000, 32'h3F800000);
    minmax_cmp(32'h3F800000, 32'hFFC00000);
    minmax_cmp(32'h7F800001, 32'h40000000);
    minmax_cmp(32'h7FC00000, 32'h7F800001);
    minmax_cmp(32'h7FA00000, 32'hFF800001);
    minmax_cmp(32'h3F800000, 32'h3F800000);
    minmax_cmp(32'hBFC00000, 32'h40400000);
    for (int k = 0; k < 16; k++) begin
      minmax_cmp($random(seed), $random(seed));
    end
    end_test("minmax_compare");

    foreach (class_vals[k]) begin
      nc_op(FPX_F7_FCLASS_FMVXW, FPX_F3_FCLASS, class_vals[k], 32'd0, 32'd0);
    end
    end_test("classify");

    // Every mode, static with a random CSR and then dynamic
    for (int m = 0; m < 5; m++) begin
      foreach (cvt_vals[k]) begin
        cvt_op(1'b0, 3'(m), 3'($random(seed)), cvt_vals[k]);
        cvt_op(1'b1, 3'(m), 3'($random(seed)), cvt_vals[k]);
        cvt_op(1'b0, FPX_RM_DYN, 3'(m), cvt_vals[k]);
        cvt_op(1'b1, FPX_RM_DYN, 3'(m), cvt_vals[k]);
      end
    end
    for (int k = 0; k < 24; k++) begin
      cvt_op(1'($random(seed)), 3'($unsigned($random(seed)) % 5), 3'd0, $random(seed));
    end
    end_test("int_to_float");

    // Back to back with the single cycle path, then idle
    for (int k = 0; k < 6; k++) begin
      cvt_op(1'b0, FPX_RM_RNE, 3'd0, $random(seed));
      nc_op(FPX_F7_FSGNJ, FPX_F3_FSGNJX, $random(seed), $random(seed), 32'd0);
      repeat (2) @(posedge clk);
    end
    end_test("busy_timing");

    ill_op({FPX_F7_FSGNJ, 5'd0, 5'd1, 3'd0, 5'd2, 7'b0110011}, 3'd0);
    ill_op(mk_instr(FPX_F7_FSGNJ | 7'b0000001, 5'd0, FPX_F3_FSGNJ), 3'd0);
    ill_op(mk_instr(7'b0001100, 5'd0, 3'd0), 3'd0);
    ill_op(mk_instr(FPX_F7_FCVTSW, 5'd0, FPX_RM_DYN), 3'd5);
    repeat (3) @(posedge clk);
    end_test("illegal");

    $display("tests: %0d ok, %0d failed, %0d errors", tests_ok, tests_bad, errors);
    if ((tests_bad == 0) && (errors == 0)) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- flist.f
rtl/fpx_pkg.sv
rtl/fpx_decode.sv
rtl/fpx_noncomp.sv
rtl/fpx_i2f.sv
rtl/fpx_ex.sv
bench/tb_fpx_ex.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       := tb_fpx_ex
FLIST     := flist.f
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := TESTBENCH FAILED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove build output and log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failure"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
